//--- rtl/hight_pkg.sv
// ----------------------------------------------------------
// Shared widths, delta LFSR seeds and structs for the HIGHT
// engine, referenced by scoped name from every RTL module
// ----------------------------------------------------------

package hight_pkg;

  // Cipher geometry
  localparam int BLOCK_W     = 64;
  localparam int KEY_W       = 128;
  localparam int RSK_W       = 32;
  localparam int WK_W        = 32;
  localparam int NUM_ROUNDS  = 32;
  localparam int ROUND_CNT_W = 5;

  // Delta LFSR, x^7 + x^3 + 1, bit k holds s(i+k)
  localparam int DELTA_W = 7;

  // First delta of the encryption order
  localparam logic [DELTA_W-1:0] DELTA_SEED = 7'h5A;

  // Delta 127; the sequence has period 127 so it wraps onto delta 0
  localparam logic [DELTA_W-1:0] DELTA_LAST = 7'h5A;

  // Host request, op is 0 for encrypt and 1 for decrypt
  typedef struct packed {
    logic [BLOCK_W-1:0] block;
    logic [KEY_W-1:0]   key;
    logic               op;
  } hight_req_t;

  // Per-round control for the round function
  // Byte k of rsk is the k-th subkey generated for the round
  typedef struct packed {
    logic [RSK_W-1:0] rsk;
    logic             is_final;
    logic             op;
  } hight_round_t;

endpackage

//--- rtl/hight_rf.sv
// ----------------------------------------------------------
// Combinational HIGHT round, used for both directions
// ----------------------------------------------------------

`timescale 1ns/1ps

module hight_rf (
  input  logic [hight_pkg::BLOCK_W-1:0] i_rf_in,
  input  logic [hight_pkg::RSK_W-1:0]   i_rsk,
  input  logic                          i_op,
  input  logic                          i_rf_final,
  output logic [hight_pkg::BLOCK_W-1:0] o_rf_out
);

  // F0 folds rotations by 1, 2 and 7
  function automatic logic [7:0] f0(input logic [7:0] v);
    return {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[0], v[7:1]};
  endfunction

  // F1 folds rotations by 3, 4 and 6
  function automatic logic [7:0] f1(input logic [7:0] v);
    return {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]} ^ {v[1:0], v[7:2]};
  endfunction

  logic [7:0] x [8];
  logic [7:0] sk_a;
  logic [7:0] sk_b;
  logic [7:0] sk_c;
  logic [7:0] sk_d;
  logic [7:0] m3;
  logic [7:0] m2;
  logic [7:0] m1;
  logic [7:0] m0;
  logic [hight_pkg::BLOCK_W-1:0] upd;

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      x[b] = i_rf_in[8*b +: 8];
    end
  end

  // Decryption sees the subkeys in reverse generation order
  assign sk_a = i_op ? i_rsk[7:0]   : i_rsk[31:24];
  assign sk_b = i_op ? i_rsk[15:8]  : i_rsk[23:16];
  assign sk_c = i_op ? i_rsk[23:16] : i_rsk[15:8];
  assign sk_d = i_op ? i_rsk[31:24] : i_rsk[7:0];

  // Xor branches are self-inverse, add branches turn into subtract
  assign m3 = x[7] ^ (f0(x[6]) + sk_a);
  assign m1 = x[3] ^ (f0(x[2]) + sk_c);
  assign m2 = i_op ? x[5] - (f1(x[4]) ^ sk_b) : x[5] + (f1(x[4]) ^ sk_b);
  assign m0 = i_op ? x[1] - (f1(x[0]) ^ sk_d) : x[1] + (f1(x[0]) ^ sk_d);

  // Updated bytes in place, which is also the final-round layout
  assign upd = {m3, x[6], m2, x[4], m1, x[2], m0, x[0]};

  // Byte rotation, left for encrypt and right for decrypt
  always_comb begin
    if (i_rf_final) begin
      o_rf_out = upd;
    end else if (i_op) begin
      o_rf_out = {upd[7:0], upd[63:8]};
    end else begin
      o_rf_out = {upd[55:0], upd[63:56]};
    end
  end

endmodule

//--- rtl/hight_key_sched.sv
// ----------------------------------------------------------
// On-the-fly HIGHT subkeys, four per round, plus whitening
// keys; the delta LFSR runs backward for decryption
// ----------------------------------------------------------

`timescale 1ns/1ps

module hight_key_sched (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_load,
  input  logic                            i_step,
  input  logic                            i_op,
  input  logic [hight_pkg::KEY_W-1:0]     i_key,
  output hight_pkg::hight_round_t         o_round,
  output logic [hight_pkg::WK_W-1:0]      o_wk_in,
  output logic [hight_pkg::WK_W-1:0]      o_wk_out
);

  localparam int DW = hight_pkg::DELTA_W;

  // s(i+7) = s(i+3) ^ s(i)
  function automatic logic [DW-1:0] lfsr_fwd(input logic [DW-1:0] d);
    return {d[3] ^ d[0], d[6:1]};
  endfunction

  // s(i-1) = s(i+6) ^ s(i+2)
  function automatic logic [DW-1:0] lfsr_bwd(input logic [DW-1:0] d);
    return {d[5:0], d[6] ^ d[2]};
  endfunction

  logic [DW-1:0]                     lfsr_q;
  logic [DW-1:0]                     lfsr_next;
  logic [DW-1:0]                     delta [4];
  logic [hight_pkg::ROUND_CNT_W-1:0] rnd_q;
  logic [hight_pkg::RSK_W-1:0]       rsk;

  // Four consecutive deltas from the current LFSR state
  always_comb begin
    delta[0] = lfsr_q;
    for (int k = 1; k < 4; k++) begin
      delta[k] = i_op ? lfsr_bwd(delta[k-1]) : lfsr_fwd(delta[k-1]);
    end
    lfsr_next = i_op ? lfsr_bwd(delta[3]) : lfsr_fwd(delta[3]);
  end

  // Subkey n = 16i + j uses MK byte {j[3], (j[2:0] - i) mod 8}
  always_comb begin
    logic [6:0] idx;
    logic [3:0] mk_sel;
    rsk = '0;
    for (int k = 0; k < 4; k++) begin
      idx = {rnd_q, 2'(k)};
      // Decryption walks the subkeys from 127 down
      if (i_op) begin
        idx = ~idx;
      end
      mk_sel = {idx[3], idx[2:0] - idx[6:4]};
      rsk[8*k +: 8] = i_key[8*mk_sel +: 8] + {1'b0, delta[k]};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lfsr_q <= hight_pkg::DELTA_SEED;
      rnd_q  <= '0;
    end else if (i_load) begin
      // Both directions start from delta 0 since delta 127 wraps onto it
      lfsr_q <= hight_pkg::DELTA_SEED;
      rnd_q  <= '0;
    end else if (i_step) begin
      lfsr_q <= lfsr_next;
      rnd_q  <= rnd_q + 1'b1;
    end
  end

  assign o_round.rsk      = rsk;
  assign o_round.is_final = (rnd_q == hight_pkg::ROUND_CNT_W'(hight_pkg::NUM_ROUNDS - 1));
  assign o_round.op       = i_op;

  // WK0..3 are MK12..15, WK4..7 are MK0..3; decryption swaps them
  assign o_wk_in  = i_op ? i_key[hight_pkg::WK_W-1:0]
                         : i_key[hight_pkg::KEY_W-1 -: hight_pkg::WK_W];
  assign o_wk_out = i_op ? i_key[hight_pkg::KEY_W-1 -: hight_pkg::WK_W]
                         : i_key[hight_pkg::WK_W-1:0];

endmodule

//--- rtl/hight_ctrl.sv
// ----------------------------------------------------------
// HIGHT round controller: state register, whitening, round
// count and the start, busy and done strobes
// ----------------------------------------------------------

`timescale 1ns/1ps

module hight_ctrl (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_start,
  input  hight_pkg::hight_req_t           i_req,
  input  logic [hight_pkg::BLOCK_W-1:0]   i_rf_out,
  input  logic [hight_pkg::WK_W-1:0]      i_wk_in,
  input  logic [hight_pkg::WK_W-1:0]      i_wk_out,
  output logic [hight_pkg::BLOCK_W-1:0]   o_rf_in,
  output logic                            o_op,
  output logic [hight_pkg::KEY_W-1:0]     o_key,
  output logic                            o_load,
  output logic                            o_step,
  output logic                            o_busy,
  output logic                            o_done,
  output logic [hight_pkg::BLOCK_W-1:0]   o_data
);

  localparam int BW = hight_pkg::BLOCK_W;
  localparam logic [hight_pkg::ROUND_CNT_W-1:0] LAST_RND =
    hight_pkg::ROUND_CNT_W'(hight_pkg::NUM_ROUNDS - 1);

  // Bytes 0 and 4 take add or subtract, bytes 2 and 6 take xor
  function automatic logic [BW-1:0] whiten(
    input logic [BW-1:0]              blk,
    input logic [hight_pkg::WK_W-1:0] wk,
    input logic                       dec
  );
    logic [BW-1:0] res;
    res        = blk;
    res[7:0]   = dec ? blk[7:0] - wk[7:0] : blk[7:0] + wk[7:0];
    res[23:16] = blk[23:16] ^ wk[15:8];
    res[39:32] = dec ? blk[39:32] - wk[23:16] : blk[39:32] + wk[23:16];
    res[55:48] = blk[55:48] ^ wk[31:24];
    return res;
  endfunction

  logic                              start_acc;
  logic                              busy_q;
  logic                              done_q;
  logic [hight_pkg::ROUND_CNT_W-1:0] cnt_q;
  logic [BW-1:0]                     state_q;
  logic [BW-1:0]                     data_q;
  logic [hight_pkg::KEY_W-1:0]       key_q;
  logic                              op_q;

  assign start_acc = i_start & ~busy_q;

  // Key and direction bypass the registers on the start cycle
  // so the input whitening key is ready before the first edge
  assign o_key  = start_acc ? i_req.key : key_q;
  assign o_op   = start_acc ? i_req.op  : op_q;
  assign o_load = start_acc;
  assign o_step = busy_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
      data_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_acc) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Output whitening rides on the last round
        if (cnt_q == LAST_RND) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          data_q <= whiten(i_rf_out, i_wk_out, op_q);
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (start_acc) begin
      state_q <= whiten(i_req.block, i_wk_in, i_req.op);
      key_q   <= i_req.key;
      op_q    <= i_req.op;
    end else if (busy_q) begin
      state_q <= i_rf_out;
    end
  end

  assign o_rf_in = state_q;
  assign o_busy  = busy_q;
  assign o_done  = done_q;
  assign o_data  = data_q;

endmodule

//--- rtl/hight_top.sv
// ----------------------------------------------------------
// HIGHT engine top: controller, key schedule, round function
// ----------------------------------------------------------

`timescale 1ns/1ps

module hight_top (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_start,
  input  hight_pkg::hight_req_t         i_req,
  output logic                          o_busy,
  output logic                          o_done,
  output logic [hight_pkg::BLOCK_W-1:0] o_data
);

  logic [hight_pkg::BLOCK_W-1:0] rf_in;
  logic [hight_pkg::BLOCK_W-1:0] rf_out;
  logic [hight_pkg::WK_W-1:0]    wk_in;
  logic [hight_pkg::WK_W-1:0]    wk_out;
  logic [hight_pkg::KEY_W-1:0]   key;
  logic                          op;
  logic                          load;
  logic                          step;
  hight_pkg::hight_round_t       round;

  hight_ctrl u_ctrl (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (i_start),
    .i_req    (i_req),
    .i_rf_out (rf_out),
    .i_wk_in  (wk_in),
    .i_wk_out (wk_out),
    .o_rf_in  (rf_in),
    .o_op     (op),
    .o_key    (key),
    .o_load   (load),
    .o_step   (step),
    .o_busy   (o_busy),
    .o_done   (o_done),
    .o_data   (o_data)
  );

  hight_key_sched u_key_sched (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_load   (load),
    .i_step   (step),
    .i_op     (op),
    .i_key    (key),
    .o_round  (round),
    .o_wk_in  (wk_in),
    .o_wk_out (wk_out)
  );

  hight_rf u_rf (
    .i_rf_in    (rf_in),
    .i_rsk      (round.rsk),
    .i_op       (round.op),
    .i_rf_final (round.is_final),
    .o_rf_out   (rf_out)
  );

endmodule

//--- verification/tb_clk_gen.sv
// ----------------------------------------------------------
// Testbench clock source, 4 ns period
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

endmodule

//--- verification/hight_model.svh
// ----------------------------------------------------------
// HIGHT reference model, whole-block encrypt and decrypt;
// included inside the testbench module
// ----------------------------------------------------------

`ifndef HIGHT_MODEL_SVH
`define HIGHT_MODEL_SVH

function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
  return (v << n) | (v >> (8 - n));
endfunction

function automatic logic [7:0] f0_ref(input logic [7:0] v);
  return rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 7);
endfunction

function automatic logic [7:0] f1_ref(input logic [7:0] v);
  return rotl8(v, 3) ^ rotl8(v, 4) ^ rotl8(v, 6);
endfunction

// WK0..3 come from MK12..15, WK4..7 from MK0..3
function automatic logic [7:0] wk_at(input logic [127:0] mk, input int i);
  return (i < 4) ? mk[8*(i+12) +: 8] : mk[8*(i-4) +: 8];
endfunction

// Even bytes 0 and 4 take add or subtract, bytes 2 and 6 take xor
function automatic logic [63:0] wk_apply(
  input logic [63:0]  v,
  input logic [127:0] mk,
  input int           base,
  input logic         sub
);
  logic [63:0] r;
  r = v;
  for (int k = 0; k < 4; k++) begin
    if (k % 2 == 1) begin
      r[16*k +: 8] = v[16*k +: 8] ^ wk_at(mk, base + k);
    end else if (sub) begin
      r[16*k +: 8] = v[16*k +: 8] - wk_at(mk, base + k);
    end else begin
      r[16*k +: 8] = v[16*k +: 8] + wk_at(mk, base + k);
    end
  end
  return r;
endfunction

function automatic logic [63:0] hight_ref(
  input logic [63:0]  blk,
  input logic [127:0] mk,
  input logic         dec
);
  logic [139:0] s;
  logic [7:0]   sk [128];
  logic [7:0]   x [8];
  logic [7:0]   t;
  logic [63:0]  v;
  int           sel;
  int           r;
  // Delta bit stream, delta n is s(n+6)..s(n)
  s = '0;
  s[6:0] = 7'b1011010;
  for (int m = 0; m < 133; m++) begin
    s[m+7] = s[m+3] ^ s[m];
  end
  // SK(16i+j) uses MK((j-i) mod 8), upper half of the key for j >= 8
  for (int n = 0; n < 128; n++) begin
    sel = ((n % 8) - n / 16 + 8) % 8 + 8 * ((n % 16) / 8);
    sk[n] = mk[8*sel +: 8] + {1'b0, s[n +: 7]};
  end
  v = wk_apply(blk, mk, dec ? 4 : 0, dec);
  for (int k = 0; k < 8; k++) begin
    x[k] = v[8*k +: 8];
  end
  for (int i = 0; i < 32; i++) begin
    r = dec ? 31 - i : i;
    // Undo the byte rotation before inverting a round
    if (dec && r < 31) begin
      t = x[0];
      for (int k = 0; k < 7; k++) begin
        x[k] = x[k+1];
      end
      x[7] = t;
    end
    if (dec) begin
      x[1] = x[1] - (f1_ref(x[0]) ^ sk[4*r]);
      x[5] = x[5] - (f1_ref(x[4]) ^ sk[4*r+2]);
    end else begin
      x[1] = x[1] + (f1_ref(x[0]) ^ sk[4*r]);
      x[5] = x[5] + (f1_ref(x[4]) ^ sk[4*r+2]);
    end
    x[3] = x[3] ^ (f0_ref(x[2]) + sk[4*r+1]);
    x[7] = x[7] ^ (f0_ref(x[6]) + sk[4*r+3]);
    if (!dec && r < 31) begin
      t = x[7];
      for (int k = 7; k > 0; k--) begin
        x[k] = x[k-1];
      end
      x[0] = t;
    end
  end
  for (int k = 0; k < 8; k++) begin
    v[8*k +: 8] = x[k];
  end
  return wk_apply(v, mk, dec ? 0 : 4, dec);
endfunction

`endif

//--- verification/hight_tb.sv
// ----------------------------------------------------------
// Random-stimulus testbench for the HIGHT engine, results
// compared with the included reference model
// ----------------------------------------------------------

`timescale 1ns/1ps

module hight_tb;

  localparam int N_RAND    = 200;
  localparam int N_B2B     = 20;
  localparam int N_OPS     = 2 + 2 * N_RAND + 2 + N_B2B;
  localparam int WD_CYCLES = N_OPS * 40 + 100;

  // Published vector with the all-zero plaintext
  localparam logic [127:0] VEC_KEY = 128'h00112233_44556677_8899aabb_ccddeeff;
  localparam logic [63:0]  VEC_CT  = 64'h00f418ae_d94f03f2;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_start;
  hight_pkg::hight_req_t i_req;
  logic                  o_busy;
  logic                  o_done;
  logic [63:0]           o_data;

  logic [63:0]  last_data;
  logic [63:0]  res;
  logic [63:0]  blk;
  logic [127:0] key;
  logic         op;
  integer       seed;

  `include "hight_model.svh"

  tb_clk_gen u_clk_gen (
    .o_clk (i_clk)
  );

  hight_top dut (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (i_start),
    .i_req   (i_req),
    .o_busy  (o_busy),
    .o_done  (o_done),
    .o_data  (o_data)
  );

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic hight_pkg::hight_req_t make_req(
    input logic [63:0]  b,
    input logic [127:0] k,
    input logic         dir
  );
    hight_pkg::hight_req_t r;
    r.block = b;
    r.key   = k;
    r.op    = dir;
    return r;
  endfunction

  task automatic draw_operands(output logic [63:0] b, output logic [127:0] k);
    b = {$random(seed), $random(seed)};
    k = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // Idle cycles after a completion, no done pulse and a steady result
  task automatic quiet(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
      check_eq(o_done, 1'b0, "unexpected o_done");
      check_eq(o_busy, 1'b0, "o_busy while idle");
      check_eq(o_data, last_data, "o_data changed while idle");
    end
  endtask

  // One operation; poke_at >= 0 issues a second start that must be ignored
  task automatic run_op(input hight_pkg::hight_req_t req, input int poke_at,
                        output logic [63:0] result);
    int cycles;
    cycles  = 0;
    i_req   = req;
    i_start = 1'b1;
    @(posedge i_clk);
    #1;
    i_start = 1'b0;
    while (o_done !== 1'b1) begin
      check_eq(o_busy, 1'b1, "o_busy during operation");
      check_eq(o_data, last_data, "o_data changed between completions");
      if (cycles == poke_at) begin
        i_req.block = ~req.block;
        i_req.key   = ~req.key;
        i_start     = 1'b1;
      end else begin
        i_start = 1'b0;
      end
      @(posedge i_clk);
      #1;
      cycles++;
    end
    i_start = 1'b0;
    check_eq(cycles, 32, "cycles from start to o_done");
    check_eq(o_busy, 1'b0, "o_busy after o_done");
    result    = o_data;
    last_data = o_data;
  endtask

  initial begin
    repeat (WD_CYCLES) @(posedge i_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  initial begin
    seed      = 32'hf79690f3;
    i_rst     = 1'b1;
    i_start   = 1'b0;
    i_req     = '0;
    last_data = '0;
    repeat (10) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    check_eq(o_busy, 1'b0, "o_busy after reset");
    check_eq(o_done, 1'b0, "o_done after reset");
    check_eq(o_data, 64'h0, "o_data after reset");

    check_eq(hight_ref(64'h0, VEC_KEY, 1'b0), VEC_CT, "model against published vector");
    run_op(make_req(64'h0, VEC_KEY, 1'b0), -1, res);
    check_eq(res, VEC_CT, "vector encryption");
    run_op(make_req(VEC_CT, VEC_KEY, 1'b1), -1, res);
    check_eq(res, 64'h0, "vector decryption");

    // Random encryptions with short idle gaps
    for (int n = 0; n < N_RAND; n++) begin
      draw_operands(blk, key);
      idle($unsigned($random(seed)) % 4);
      run_op(make_req(blk, key, 1'b0), -1, res);
      check_eq(res, hight_ref(blk, key, 1'b0), "random encryption");
    end

    // Decrypting model ciphertexts gives the plaintext back
    for (int n = 0; n < N_RAND; n++) begin
      draw_operands(blk, key);
      run_op(make_req(hight_ref(blk, key, 1'b0), key, 1'b1), -1, res);
      check_eq(res, blk, "random decryption");
    end

    draw_operands(blk, key);
    run_op(make_req(blk, key, 1'b0), 10, res);
    check_eq(res, hight_ref(blk, key, 1'b0), "result after start during busy");
    quiet(40);

    // Back-to-back, mixed directions
    for (int n = 0; n < N_B2B; n++) begin
      draw_operands(blk, key);
      op = blk[63];
      run_op(make_req(blk, key, op), -1, res);
      check_eq(res, hight_ref(blk, key, op), "back-to-back result");
    end

    $display("** PASS **");
    $finish;
  end

endmodule

//--- list.f
+incdir+verification
rtl/hight_pkg.sv
rtl/hight_rf.sv
rtl/hight_key_sched.sv
rtl/hight_ctrl.sv
rtl/hight_top.sv
verification/tb_clk_gen.sv
verification/hight_tb.sv

//--- Bender.yml
package:
  name: hight

sources:
  - files:
      - rtl/hight_pkg.sv
      - rtl/hight_rf.sv
      - rtl/hight_key_sched.sv
      - rtl/hight_ctrl.sv
      - rtl/hight_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_clk_gen.sv
      - verification/hight_tb.sv
